// ==== Bender.yml ====
package:
  name: bw_test

sources:
  # Design, in compile order
  - hw/bw_test_pkg.sv
  - hw/bw_csr_regs.sv
  - hw/bw_run_ctrl.sv
  - hw/bw_req_stream.sv
  - hw/bw_stream_stats.sv
  - hw/bw_test_top.sv
  # Testbench
  - target: test
    files:
      - verification/bw_test_tb.sv

// ==== bw_test_top.f ====
hw/bw_test_pkg.sv
hw/bw_csr_regs.sv
hw/bw_run_ctrl.sv
hw/bw_req_stream.sv
hw/bw_stream_stats.sv
hw/bw_test_top.sv
verification/bw_test_tb.sv

// ==== hw/bw_csr_regs.sv ====
// Bandwidth test CSR bank
// Holds host-written configuration and returns results through a
// registered read mux

`timescale 1ns/1ps

module bw_csr_regs
    import bw_test_pkg::*;
#(
    parameter int N_MEM_REGION_BITS = 24
)
(
    input  logic          clk,
    input  logic          reset,
    input  csr_wr_t       csr_wr,
    input  csr_idx_t      csr_rd_idx,
    input  run_state_t    state,
    input  logic          rd_almfull_q,
    input  logic          wr_almfull_q,
    input  counter_t      cycles_executed,
    input  stream_stats_t rd_stats,
    input  stream_stats_t wr_stats,
    output test_cfg_t     cfg,
    output counter_t      cycles_load,
    output logic          cycles_load_en,
    output logic [63:0]   csr_rd_data
);

    // Limits the buffer mask to the allocated region
    localparam logic [ADDR_W-1:0] REGION_MASK =
        ADDR_W'((64'(1) << N_MEM_REGION_BITS) - 64'(1));

    // Run length goes straight to run control
    assign cycles_load    = counter_t'(csr_wr.data);
    assign cycles_load_en = csr_wr.valid && (csr_wr.idx == CSR_CYCLES);

    // ====================
    // Host writes
    // ====================
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            cfg <= '0;
        end
        else if (csr_wr.valid)
        begin
            case (csr_wr.idx)
                CSR_RD_BASE:  cfg.rd_base <= csr_wr.data[ADDR_W-1:0];
                CSR_WR_BASE:  cfg.wr_base <= csr_wr.data[ADDR_W-1:0];
                CSR_MEM_MASK: cfg.mem_mask <= csr_wr.data[ADDR_W-1:0] & REGION_MASK;
                CSR_CONFIG:
                begin
                    // Stride above the two enable bits
                    cfg.stride        <= csr_wr.data[17:2];
                    cfg.enable_writes <= csr_wr.data[1];
                    cfg.enable_reads  <= csr_wr.data[0];
                end
                CSR_INTERVAL:
                begin
                    cfg.wr_interval <= csr_wr.data[15:8];
                    cfg.rd_interval <= csr_wr.data[7:0];
                end
                default:
                begin
                end
            endcase
        end
    end

    // ====================
    // Host reads
    // ====================
    // Data shows up one cycle after the index
    always_ff @(posedge clk)
    begin
        case (csr_rd_idx)
            RD_CSR_CYCLES_EXEC: csr_rd_data <= 64'(cycles_executed);
            RD_CSR_RD_RSP:      csr_rd_data <= 64'(rd_stats.rsp_cnt);
            RD_CSR_WR_RSP:      csr_rd_data <= 64'(wr_stats.rsp_cnt);
            // State in bits 15:8, registered almost-full flags in bits 1:0
            RD_CSR_STATUS:
                csr_rd_data <= {48'(0), 8'(state), 6'(0), wr_almfull_q, rd_almfull_q};
            RD_CSR_RD_MAX:      csr_rd_data <= 64'(rd_stats.inflight_max);
            RD_CSR_WR_MAX:      csr_rd_data <= 64'(wr_stats.inflight_max);
            RD_CSR_RD_TOTAL:    csr_rd_data <= rd_stats.inflight_total;
            default:            csr_rd_data <= wr_stats.inflight_total;
        endcase
    end

endmodule

// ==== hw/bw_req_stream.sv ====
// Bandwidth test request stream
// Paces single-line requests and walks a strided offset through a
// masked buffer, rotating the restart base on each wrap

`timescale 1ns/1ps

module bw_req_stream
    import bw_test_pkg::*;
#(
    parameter int N_MEM_REGION_BITS = 24
)
(
    input  logic              clk,
    input  logic              reset,
    input  logic              start,
    input  logic              enable,
    input  logic              almfull,
    input  logic [7:0]        interval,
    input  stride_t           stride,
    input  logic [ADDR_W-1:0] base,
    input  logic [ADDR_W-1:0] mem_mask,
    output mem_req_t          req,
    output logic              almfull_q
);

    // Offsets live in the region plus one carry bit, so running past the
    // top of a full-region mask still reads as leaving the buffer
    typedef logic [N_MEM_REGION_BITS:0] offset_t;

    logic [7:0] pace_cnt;
    logic       pace_tick;
    logic       do_issue;
    offset_t    region_mask;
    offset_t    offset;
    offset_t    offset_next;
    stride_t    rot_base;
    stride_t    rot_base_max;
    stride_t    rot_base_first;

    // Port back-pressure, held asserted through reset
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            almfull_q <= 1'b1;
        end
        else
        begin
            almfull_q <= almfull;
        end
    end

    // ====================
    // Load pacer
    // ====================
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            pace_cnt  <= '0;
            pace_tick <= 1'b0;
        end
        else
        begin
            pace_tick <= (pace_cnt == '0);
            pace_cnt  <= (pace_cnt == '0) ? interval : pace_cnt - 8'd1;
        end
    end

    // Ticks lost while stalled are not made up later
    assign do_issue = enable && pace_tick && !almfull_q;

    // ====================
    // Address walker
    // ====================
    assign region_mask = {1'b0, mem_mask[N_MEM_REGION_BITS-1:0]};

    // Largest restart base, one line below the stride inside the buffer
    assign rot_base_max = (stride == '0) ? '0 : (stride - stride_t'(1)) & stride_t'(mem_mask);

    // Offset 0 opens the run, so the first wrap already uses the next base
    assign rot_base_first = (rot_base_max == '0) ? '0 : stride_t'(1);

    always_ff @(posedge clk)
    begin
        if (reset || start)
        begin
            offset      <= '0;
            offset_next <= offset_t'(stride);
            rot_base    <= rot_base_first;
        end
        else if (do_issue)
        begin
            if (|(offset_next & ~region_mask))
            begin
                // Left the buffer, restart at the rotating base
                offset      <= offset_t'(rot_base);
                offset_next <= offset_t'(rot_base) + offset_t'(stride);
                rot_base    <= (rot_base < rot_base_max) ? rot_base + stride_t'(1) : '0;
            end
            else
            begin
                offset      <= offset_next;
                offset_next <= offset_next + offset_t'(stride);
            end
        end
    end

    // Registered request, one cycle after the issue decision
    always_ff @(posedge clk)
    begin
        req.addr <= base + ADDR_W'(offset);
        if (reset)
        begin
            req.valid <= 1'b0;
        end
        else
        begin
            req.valid <= do_issue;
        end
    end

endmodule

// ==== hw/bw_run_ctrl.sv ====
// Bandwidth test run control
// Idle, run and terminate FSM with the remaining-cycle and
// executed-cycle counters

`timescale 1ns/1ps

module bw_run_ctrl
    import bw_test_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  test_cfg_t  cfg,
    input  counter_t   cycles_load,
    input  logic       cycles_load_en,
    input  logic       rd_busy,
    input  logic       wr_busy,
    output logic       start,
    output logic       rd_enable,
    output logic       wr_enable,
    output run_state_t state,
    output counter_t   cycles_executed
);

    counter_t cycles_rem;

    // Remaining cycles are loaded by the host and run down to zero
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            cycles_rem <= '0;
        end
        else if (cycles_load_en)
        begin
            cycles_rem <= cycles_load;
        end
        else if (cycles_rem != '0)
        begin
            cycles_rem <= cycles_rem - counter_t'(1);
        end
    end

    // ====================
    // Run FSM
    // ====================
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            start           <= 1'b0;
            state           <= ST_IDLE;
            rd_enable       <= 1'b0;
            wr_enable       <= 1'b0;
            cycles_executed <= '0;
        end
        else
        begin
            // One-cycle pulse after the cycle count write
            start <= cycles_load_en;

            case (state)
                ST_IDLE:
                begin
                    if (start)
                    begin
                        // Last run's count stays readable until the next start
                        cycles_executed <= '0;
                        state           <= ST_RUN;
                        rd_enable       <= cfg.enable_reads;
                        wr_enable       <= cfg.enable_writes;
                    end
                end
                ST_RUN:
                begin
                    cycles_executed <= cycles_executed + counter_t'(1);
                    if (cycles_rem == '0)
                    begin
                        state     <= ST_TERMINATE;
                        rd_enable <= 1'b0;
                        wr_enable <= 1'b0;
                    end
                end
                ST_TERMINATE:
                begin
                    cycles_executed <= cycles_executed + counter_t'(1);
                    // Drain until nothing is issued or outstanding
                    if (!rd_busy && !wr_busy)
                    begin
                        state <= ST_IDLE;
                    end
                end
                default:
                begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

// ==== hw/bw_stream_stats.sv ====
// Bandwidth test stream statistics
// Response count plus in-flight current, maximum and running total
// for Little's Law latency

`timescale 1ns/1ps

module bw_stream_stats
    import bw_test_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  logic          start,
    input  logic          issue,
    input  logic          rsp,
    output stream_stats_t stats,
    output logic          busy
);

    counter_t inflight_now;

    always_ff @(posedge clk)
    begin
        if (reset || start)
        begin
            inflight_now         <= '0;
            stats.rsp_cnt        <= '0;
            stats.inflight_max   <= '0;
            stats.inflight_total <= '0;
        end
        else
        begin
            if (rsp)
            begin
                stats.rsp_cnt <= stats.rsp_cnt + counter_t'(1);
            end

            // Request and response together leave the count unchanged
            if (issue != rsp)
            begin
                inflight_now <= rsp ? inflight_now - counter_t'(1)
                                    : inflight_now + counter_t'(1);
            end

            // Max and total follow the current count every cycle
            if (inflight_now > stats.inflight_max)
            begin
                stats.inflight_max <= inflight_now;
            end
            stats.inflight_total <= stats.inflight_total + total_t'(inflight_now);
        end
    end

    // A request on the port is not yet counted, so it keeps the stream busy too
    assign busy = issue || (inflight_now != '0);

endmodule

// ==== hw/bw_test_pkg.sv ====
// Memory bandwidth test engine shared definitions
// Widths, CSR map, configuration, request and statistics types

package bw_test_pkg;

    // Line address width
    localparam int ADDR_W = 48;

    typedef logic [31:0] counter_t;
    typedef logic [63:0] total_t;
    typedef logic [15:0] stride_t;

    // ====================
    // CSR map
    // ====================
    localparam int N_CSRS = 8;
    typedef logic [$clog2(N_CSRS)-1:0] csr_idx_t;

    // Host write side, a write to CSR_CYCLES starts a run
    localparam csr_idx_t CSR_CYCLES   = 3'd0;
    localparam csr_idx_t CSR_RD_BASE  = 3'd1;
    localparam csr_idx_t CSR_WR_BASE  = 3'd2;
    localparam csr_idx_t CSR_MEM_MASK = 3'd3;
    localparam csr_idx_t CSR_CONFIG   = 3'd4;
    localparam csr_idx_t CSR_INTERVAL = 3'd5;

    // Host read side
    localparam csr_idx_t RD_CSR_CYCLES_EXEC = 3'd0;
    localparam csr_idx_t RD_CSR_RD_RSP      = 3'd1;
    localparam csr_idx_t RD_CSR_WR_RSP      = 3'd2;
    localparam csr_idx_t RD_CSR_STATUS      = 3'd3;
    localparam csr_idx_t RD_CSR_RD_MAX      = 3'd4;
    localparam csr_idx_t RD_CSR_WR_MAX      = 3'd5;
    localparam csr_idx_t RD_CSR_RD_TOTAL    = 3'd6;
    localparam csr_idx_t RD_CSR_WR_TOTAL    = 3'd7;

    // One-cycle host write strobe
    typedef struct packed {
        logic        valid;
        csr_idx_t    idx;
        logic [63:0] data;
    } csr_wr_t;

    typedef struct packed {
        stride_t           stride;
        logic              enable_reads;
        logic              enable_writes;
        logic [7:0]        rd_interval;
        logic [7:0]        wr_interval;
        logic [ADDR_W-1:0] rd_base;
        logic [ADDR_W-1:0] wr_base;
        logic [ADDR_W-1:0] mem_mask;
    } test_cfg_t;

    // Single-line request strobe
    typedef struct packed {
        logic              valid;
        logic [ADDR_W-1:0] addr;
    } mem_req_t;

    typedef struct packed {
        counter_t rsp_cnt;
        counter_t inflight_max;
        total_t   inflight_total;
    } stream_stats_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RUN,
        ST_TERMINATE
    } run_state_t;

endpackage

// ==== hw/bw_test_top.sv ====
// Memory bandwidth test engine top level
// CSR bank, run control, and a read and a write stream with their
// statistics blocks

`timescale 1ns/1ps

module bw_test_top
    import bw_test_pkg::*;
#(
    parameter int N_MEM_REGION_BITS = 24
)
(
    input  logic        clk,
    input  logic        reset,
    input  csr_wr_t     csr_wr,
    input  csr_idx_t    csr_rd_idx,
    input  logic        rd_almfull,
    input  logic        wr_almfull,
    input  logic        rd_rsp,
    input  logic        wr_rsp,
    output logic [63:0] csr_rd_data,
    output mem_req_t    rd_req,
    output mem_req_t    wr_req
);

    test_cfg_t     cfg;
    counter_t      cycles_load;
    logic          cycles_load_en;
    logic          start;
    logic          rd_enable;
    logic          wr_enable;
    run_state_t    state;
    counter_t      cycles_executed;
    logic          rd_almfull_q;
    logic          wr_almfull_q;
    stream_stats_t rd_stats;
    stream_stats_t wr_stats;
    logic          rd_busy;
    logic          wr_busy;

    // ====================
    // Control
    // ====================
    bw_csr_regs #(
        .N_MEM_REGION_BITS(N_MEM_REGION_BITS)
    ) csr_regs (
        .clk, .reset, .csr_wr, .csr_rd_idx, .state,
        .rd_almfull_q, .wr_almfull_q, .cycles_executed,
        .rd_stats, .wr_stats,
        .cfg, .cycles_load, .cycles_load_en, .csr_rd_data
    );

    bw_run_ctrl run_ctrl (
        .clk, .reset, .cfg, .cycles_load, .cycles_load_en,
        .rd_busy, .wr_busy,
        .start, .rd_enable, .wr_enable, .state, .cycles_executed
    );

    // ====================
    // Streams
    // ====================
    bw_req_stream #(
        .N_MEM_REGION_BITS(N_MEM_REGION_BITS)
    ) rd_stream (
        .clk, .reset, .start,
        .enable(rd_enable), .almfull(rd_almfull), .interval(cfg.rd_interval),
        .stride(cfg.stride), .base(cfg.rd_base), .mem_mask(cfg.mem_mask),
        .req(rd_req), .almfull_q(rd_almfull_q)
    );

    bw_req_stream #(
        .N_MEM_REGION_BITS(N_MEM_REGION_BITS)
    ) wr_stream (
        .clk, .reset, .start,
        .enable(wr_enable), .almfull(wr_almfull), .interval(cfg.wr_interval),
        .stride(cfg.stride), .base(cfg.wr_base), .mem_mask(cfg.mem_mask),
        .req(wr_req), .almfull_q(wr_almfull_q)
    );

    // Stats count the request strobe itself as the issue event
    bw_stream_stats rd_stats_i (
        .clk, .reset, .start, .issue(rd_req.valid), .rsp(rd_rsp),
        .stats(rd_stats), .busy(rd_busy)
    );

    bw_stream_stats wr_stats_i (
        .clk, .reset, .start, .issue(wr_req.valid), .rsp(wr_rsp),
        .stats(wr_stats), .busy(wr_busy)
    );

endmodule

// ==== verification/bw_test_stimulus.txt ====
// Bandwidth test stimulus, five records of 19 hex words, one record per line
// Columns: stride mask rd_interval wr_interval en_reads en_writes rd_base wr_base
//          run_cycles almfull_start almfull_len rd_addr0..3 wr_addr0..3
// Almost-full start counts from the cycle after start, length 0 means none

// Stride 4 over a 16-line buffer, writes every other cycle
4 F 0 1 1 1 1000 8000 40 0 0 1000 1004 1008 100C 8000 8004 8008 800C

// Stride 3 over 8 lines wraps on the third issue, almost-full window
3 7 2 0 1 1 200 300 30 8 6 200 203 206 201 300 303 306 301

// Unit stride, reads only
1 3 1 3 1 0 40 50 20 0 0 40 41 42 43 0 0 0 0

// Second run of the first setup, walk restarts at the base under back-pressure
4 F 0 0 1 1 1000 8000 50 10 8 1000 1004 1008 100C 8000 8004 8008 800C

// Zero stride holds the pointer at the base
0 FF 3 2 1 1 ABC0 DEF0 18 0 0 ABC0 ABC0 ABC0 ABC0 DEF0 DEF0 DEF0 DEF0

// ==== verification/bw_test_tb.sv ====
// Bandwidth test engine testbench
// Programs each run from a stimulus file, answers requests with a
// delayed memory responder and checks addresses, pacing,
// back-pressure, run control and statistics against its own models

`timescale 1ns/1ps

module bw_test_tb
    import bw_test_pkg::*;
();

    localparam int REC_WORDS   = 19;
    localparam int N_RECS      = 5;
    localparam int REGION_BITS = 24;

    logic          clk;
    logic          reset;
    csr_wr_t       csr_wr;
    csr_idx_t      csr_rd_idx;
    logic          rd_almfull;
    logic          wr_almfull;
    logic          rd_rsp;
    logic          wr_rsp;
    logic [63:0]   csr_rd_data;
    mem_req_t      rd_req;
    mem_req_t      wr_req;

    logic [63:0]   stim_mem [0:REC_WORDS*N_RECS-1];
    longint        cyc = 0;
    longint        clear_cyc = -1;
    longint        af_from = 0;
    longint        af_to = 0;
    longint        last_wr_cyc = 0;
    longint        watchdog_ns = 0;
    longint        total_cycles;
    bit            run_open;
    int            errors = 0;
    int            checks = 0;
    string         test_name = "reset";

    // Walker model per stream (0 read, 1 write)
    longint        m_base [2];
    longint        m_first [2][4];
    longint        m_offs [2];
    longint        m_nxt [2];
    longint        m_rb [2];
    longint        m_mask;
    longint        m_stride;
    longint        m_rb_max;
    int            m_int [2];
    bit            m_en [2];
    int            m_idx [2];

    // In-flight model and monitor state
    longint        m_cur [2];
    longint        m_max [2];
    longint        m_total [2];
    int            sent [2];
    longint        prev_req [2];
    bit            stalled [2];
    int            af_cnt [2];
    longint        last_due [2];
    longint        rd_due [$];
    longint        wr_due [$];

    bw_test_top #(
        .N_MEM_REGION_BITS(REGION_BITS)
    ) uut (
        .clk, .reset, .csr_wr, .csr_rd_idx,
        .rd_almfull, .wr_almfull, .rd_rsp, .wr_rsp,
        .csr_rd_data, .rd_req, .wr_req
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cyc <= cyc + 1;
    end

    // ====================
    // Checks
    // ====================
    task automatic compare_value(input string what, input logic [63:0] exp,
                                 input logic [63:0] act);
        checks++;
        assert (act === exp)
        else
        begin
            errors++;
            $display("ERROR %s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic require(input bit cond, input string msg);
        checks++;
        assert (cond)
        else
        begin
            errors++;
            $display("ERROR %s: %s", test_name, msg);
        end
    endtask

    // Run start puts the walker back to offset 0 and clears the stats
    task automatic clear_models();
        for (int s = 0; s < 2; s++)
        begin
            m_offs[s]   = 0;
            m_nxt[s]    = m_stride;
            // Offset 0 opens the run, so the first wrap takes base 1
            m_rb[s]     = (m_rb_max == 0) ? 0 : 1;
            m_idx[s]    = 0;
            m_cur[s]    = 0;
            m_max[s]    = 0;
            m_total[s]  = 0;
            sent[s]     = 0;
            prev_req[s] = -1;
            stalled[s]  = 1'b0;
        end
    endtask

    // One cycle of one stream as seen at the falling edge
    task automatic observe_stream(input int s, input logic valid,
                                  input logic [ADDR_W-1:0] addr,
                                  input logic rsp, input logic af);
        string             sn;
        logic [ADDR_W-1:0] exp_addr;
        longint            due;
        sn = (s == 0) ? "rd" : "wr";
        if (valid)
        begin
            require(run_open && m_en[s], {sn, " request outside an enabled run"});
            require(!(af && af_cnt[s] >= 2), {sn, " request while almost-full was held"});
            exp_addr = ADDR_W'(m_base[s] + m_offs[s]);
            compare_value($sformatf("%s addr %0d", sn, m_idx[s]), 64'(exp_addr), 64'(addr));
            if (m_idx[s] < 4)
            begin
                compare_value($sformatf("%s file addr %0d", sn, m_idx[s]),
                              m_first[s][m_idx[s]], 64'(addr));
            end
            // Step the walker and restart at the rotating base on leaving the buffer
            if ((m_nxt[s] & ~m_mask) != 0)
            begin
                m_offs[s] = m_rb[s];
                m_nxt[s]  = m_rb[s] + m_stride;
                m_rb[s]   = (m_rb[s] < m_rb_max) ? m_rb[s] + 1 : 0;
            end
            else
            begin
                m_offs[s] = m_nxt[s];
                m_nxt[s]  = m_nxt[s] + m_stride;
            end
            m_idx[s]++;
            // Gap only holds while no almost-full came in between
            if (prev_req[s] >= 0 && !stalled[s])
            begin
                compare_value({sn, " gap"}, 64'(m_int[s] + 1), 64'(cyc - prev_req[s]));
            end
            prev_req[s] = cyc;
            stalled[s]  = 1'b0;
            // Responder gives one strobe per cycle at most
            due = cyc + 2 + ($urandom % 8);
            if (due <= last_due[s])
                due = last_due[s] + 1;
            last_due[s] = due;
            if (s == 0)
                rd_due.push_back(due);
            else
                wr_due.push_back(due);
        end
        // In-flight count as seen by the stats block this cycle
        m_total[s] += m_cur[s];
        if (m_cur[s] > m_max[s])
            m_max[s] = m_cur[s];
        if (valid && !rsp)
            m_cur[s]++;
        else if (rsp && !valid)
            m_cur[s]--;
        if (rsp)
            sent[s]++;
        af_cnt[s] = af ? af_cnt[s] + 1 : 0;
        if (af)
            stalled[s] = 1'b1;
    endtask

    always @(negedge clk)
    begin
        if (!reset)
        begin
            if (cyc == clear_cyc)
            begin
                clear_models();
            end
            else
            begin
                observe_stream(0, rd_req.valid, rd_req.addr, rd_rsp, rd_almfull);
                observe_stream(1, wr_req.valid, wr_req.addr, wr_rsp, wr_almfull);
            end
        end
    end

    // ====================
    // Memory port model
    // ====================
    always @(posedge clk)
    begin
        #1;
        rd_almfull = (cyc >= af_from) && (cyc < af_to);
        wr_almfull = (cyc >= af_from) && (cyc < af_to);
        rd_rsp = 1'b0;
        wr_rsp = 1'b0;
        if (rd_due.size() > 0)
        begin
            if (rd_due[0] == cyc)
            begin
                rd_rsp = 1'b1;
                void'(rd_due.pop_front());
            end
        end
        if (wr_due.size() > 0)
        begin
            if (wr_due[0] == cyc)
            begin
                wr_rsp = 1'b1;
                void'(wr_due.pop_front());
            end
        end
    end

    // ====================
    // Host CSR access
    // ====================
    task automatic csr_write(input csr_idx_t idx, input logic [63:0] data);
        @(posedge clk);
        #1;
        last_wr_cyc  = cyc;
        csr_wr.valid = 1'b1;
        csr_wr.idx   = idx;
        csr_wr.data  = data;
        @(posedge clk);
        #1;
        csr_wr.valid = 1'b0;
    endtask

    // Read data is registered and taken one cycle after the index
    task automatic csr_read(input csr_idx_t idx, output logic [63:0] data);
        @(posedge clk);
        #1;
        csr_rd_idx = idx;
        @(posedge clk);
        #1;
        data = csr_rd_data;
    endtask

    task automatic run_record(input int r);
        logic [63:0] f [0:REC_WORDS-1];
        logic [63:0] rd_val;
        logic [7:0]  st;
        int          polls;
        int          k;
        test_name = $sformatf("rec%0d", r);
        for (k = 0; k < REC_WORDS; k++)
            f[k] = stim_mem[r*REC_WORDS + k];
        m_stride = f[0];
        m_mask   = f[1] & ((64'd1 << REGION_BITS) - 1);
        m_int[0] = f[2];
        m_int[1] = f[3];
        m_en[0]  = f[4][0];
        m_en[1]  = f[5][0];
        m_base[0] = f[6];
        m_base[1] = f[7];
        m_rb_max = (m_stride == 0) ? 0 : ((m_stride - 1) & m_mask & 64'hFFFF);
        for (k = 0; k < 4; k++)
        begin
            m_first[0][k] = f[11 + k];
            m_first[1][k] = f[15 + k];
        end

        csr_write(CSR_RD_BASE, f[6]);
        csr_write(CSR_WR_BASE, f[7]);
        csr_write(CSR_MEM_MASK, f[1]);
        csr_write(CSR_CONFIG, {46'd0, f[0][15:0], f[5][0], f[4][0]});
        csr_write(CSR_INTERVAL, {48'd0, f[3][7:0], f[2][7:0]});
        run_open = 1'b1;
        csr_write(CSR_CYCLES, f[8]);
        // Start pulses the cycle after the write
        clear_cyc = last_wr_cyc + 1;
        af_from   = last_wr_cyc + 2 + f[9];
        af_to     = af_from + f[10];

        // Status samples the registered flags from two cycles into the window
        if (f[10] >= 3)
        begin
            repeat (f[9] + 3) @(posedge clk);
            csr_read(RD_CSR_STATUS, rd_val);
            compare_value("status almfull flags", 64'h3, 64'(rd_val[1:0]));
        end

        repeat (f[8] + 2) @(posedge clk);
        csr_read(RD_CSR_STATUS, rd_val);
        st = rd_val[15:8];
        require(st == ST_TERMINATE || st == ST_IDLE, "still running after the programmed cycles");
        polls = 0;
        while (st != ST_IDLE && polls < 50)
        begin
            csr_read(RD_CSR_STATUS, rd_val);
            st = rd_val[15:8];
            polls++;
        end
        require(st == ST_IDLE, "run did not return to idle");
        require(rd_due.size() == 0 && wr_due.size() == 0, "idle with responses outstanding");
        run_open = 1'b0;

        csr_read(RD_CSR_CYCLES_EXEC, rd_val);
        require(rd_val >= f[8], $sformatf("cycles_executed %0d below %0d", rd_val, f[8]));
        csr_read(RD_CSR_RD_RSP, rd_val);
        compare_value("rd rsp count", 64'(sent[0]), rd_val);
        csr_read(RD_CSR_WR_RSP, rd_val);
        compare_value("wr rsp count", 64'(sent[1]), rd_val);
        csr_read(RD_CSR_RD_MAX, rd_val);
        compare_value("rd inflight max", 64'(m_max[0]), rd_val);
        csr_read(RD_CSR_WR_MAX, rd_val);
        compare_value("wr inflight max", 64'(m_max[1]), rd_val);
        csr_read(RD_CSR_RD_TOTAL, rd_val);
        compare_value("rd inflight total", 64'(m_total[0]), rd_val);
        csr_read(RD_CSR_WR_TOTAL, rd_val);
        compare_value("wr inflight total", 64'(m_total[1]), rd_val);
        for (k = 0; k < 2; k++)
        begin
            if (m_en[k])
                require(m_idx[k] >= 4, "enabled stream issued fewer than four requests");
        end
    endtask

    // ====================
    // Main sequence
    // ====================
    initial
    begin
        void'($urandom(32'h2d7));
        reset      = 1'b1;
        csr_wr     = '0;
        csr_rd_idx = '0;
        rd_almfull = 1'b0;
        wr_almfull = 1'b0;
        rd_rsp     = 1'b0;
        wr_rsp     = 1'b0;
        run_open   = 1'b0;
        $readmemh("verification/bw_test_stimulus.txt", stim_mem);
        total_cycles = 16;
        for (int r = 0; r < N_RECS; r++)
            total_cycles += stim_mem[r*REC_WORDS + 8] + 200;
        watchdog_ns = total_cycles * 4;

        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;
        for (int r = 0; r < N_RECS; r++)
            run_record(r);
        repeat (4) @(posedge clk);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

    // Budget from the run lengths in the file
    initial
    begin
        wait (watchdog_ns != 0);
        #(watchdog_ns);
        $display("Timeout: %s still running after %0d ns", test_name, watchdog_ns);
        $display("Checks: %0d, errors: %0d", checks, errors);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule
